// ==== Bender.yml ====
package:
  name: host_mem_rdwr

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rdwr_pkg.sv
      - rtl/engine_csr_if.sv
      - rtl/csr_mgr.sv
      - rtl/host_mem_rdwr_engine.sv
      - rtl/afu.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/tb_afu.sv

// ==== afu.f ====
+incdir+rtl
rtl/rdwr_pkg.sv
rtl/engine_csr_if.sv
rtl/csr_mgr.sv
rtl/host_mem_rdwr_engine.sv
rtl/afu.sv
sim/tb_afu.sv

// ==== rtl/afu.sv ====
// Top level of the host-memory exerciser
// Global registers, copy engines per host port and the MMIO decoder

`timescale 1ns/1ps

`include "rdwr_config.svh"

module afu
(
    input  logic                                              clk,
    input  logic                                              arst_n,

    // Host memory read channel, one port per engine
    output logic [`RDWR_NUM_ENGINES-1:0]                      host_rd_read,
    output logic [`RDWR_NUM_ENGINES-1:0][`RDWR_ADDR_W-1:0]    host_rd_address,
    input  logic [`RDWR_NUM_ENGINES-1:0]                      host_rd_waitrequest,
    input  logic [`RDWR_NUM_ENGINES-1:0]                      host_rd_readdatavalid,
    input  logic [`RDWR_NUM_ENGINES-1:0][`RDWR_DATA_W-1:0]    host_rd_readdata,

    // Host memory write channel
    output logic [`RDWR_NUM_ENGINES-1:0]                      host_wr_write,
    output logic [`RDWR_NUM_ENGINES-1:0][`RDWR_ADDR_W-1:0]    host_wr_address,
    output logic [`RDWR_NUM_ENGINES-1:0][`RDWR_DATA_W-1:0]    host_wr_writedata,
    input  logic [`RDWR_NUM_ENGINES-1:0]                      host_wr_waitrequest,

    // MMIO slave
    input  logic                                              mmio_write,
    input  logic                                              mmio_read,
    input  logic [`RDWR_MMIO_ADDR_W-1:0]                      mmio_address,
    input  logic [`RDWR_DATA_W-1:0]                           mmio_writedata,
    output logic [`RDWR_DATA_W-1:0]                           mmio_readdata,
    output logic                                              mmio_readdatavalid,
    output logic                                              mmio_waitrequest,
    output logic [1:0]                                        mmio_response
);

    localparam logic [127:0] TEST_ID = `RDWR_TEST_ID;

    engine_csr_if eng_csr_glob ();
    engine_csr_if eng_csr [`RDWR_NUM_ENGINES] ();

    // ========================================
    // Global registers
    // ========================================

    // Tells software which test this is and how many engines it can drive
    always_comb
    begin
        for (int i = 0; i < `RDWR_NUM_CSRS; i++)
            eng_csr_glob.rd_data[i] = '0;
        eng_csr_glob.rd_data[0] = TEST_ID[63:0];
        eng_csr_glob.rd_data[1] = TEST_ID[127:64];
        eng_csr_glob.rd_data[2] = `RDWR_DATA_W'(`RDWR_NUM_ENGINES);
        // No job runs in the global block
        eng_csr_glob.status_active = 1'b0;
    end

    // ========================================
    // Copy engines
    // ========================================

    for (genvar p = 0; p < `RDWR_NUM_ENGINES; p++)
    begin : g_eng
        host_mem_rdwr_engine #(
            .ENGINE_NUMBER (p)
        ) eng (
            .clk              (clk),
            .arst_n           (arst_n),
            .csrs             (eng_csr[p]),
            .rd_read          (host_rd_read[p]),
            .rd_address       (host_rd_address[p]),
            .rd_waitrequest   (host_rd_waitrequest[p]),
            .rd_readdatavalid (host_rd_readdatavalid[p]),
            .rd_readdata      (host_rd_readdata[p]),
            .wr_write         (host_wr_write[p]),
            .wr_address       (host_wr_address[p]),
            .wr_writedata     (host_wr_writedata[p]),
            .wr_waitrequest   (host_wr_waitrequest[p])
        );
    end

    // MMIO decode for all blocks
    csr_mgr u_csr_mgr (
        .clk                (clk),
        .arst_n             (arst_n),
        .mmio_write         (mmio_write),
        .mmio_read          (mmio_read),
        .mmio_address       (mmio_address),
        .mmio_writedata     (mmio_writedata),
        .mmio_readdata      (mmio_readdata),
        .mmio_readdatavalid (mmio_readdatavalid),
        .eng_csr_glob       (eng_csr_glob),
        .eng_csr            (eng_csr)
    );

    // Every access is taken at once and always succeeds
    assign mmio_waitrequest = 1'b0;
    assign mmio_response    = 2'b00;

endmodule

// ==== rtl/csr_mgr.sv ====
// MMIO register decoder for the exerciser
// Routes writes to engines and returns registered read data

`timescale 1ns/1ps

`include "rdwr_config.svh"

module csr_mgr
    import rdwr_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,

    input  logic                    mmio_write,
    input  logic                    mmio_read,
    input  mmio_addr_u              mmio_address,
    input  logic [`RDWR_DATA_W-1:0] mmio_writedata,
    output logic [`RDWR_DATA_W-1:0] mmio_readdata,
    output logic                    mmio_readdatavalid,

    engine_csr_if.mgr               eng_csr_glob,
    engine_csr_if.mgr               eng_csr [`RDWR_NUM_ENGINES]
);

    localparam int NUM_ENG = `RDWR_NUM_ENGINES;
    localparam int NUM_CSR = `RDWR_NUM_CSRS;
    // The eng_sel field can name this many engines
    localparam int MAX_ENG = 8;

    // Read words of every engine slot the address map can select
    logic [`RDWR_DATA_W-1:0] eng_rd [MAX_ENG][NUM_CSR];

    // ========================================
    // Write routing
    // ========================================

    // The global block is read only, so it never sees a strobe
    assign eng_csr_glob.wr_en   = 1'b0;
    assign eng_csr_glob.wr_idx  = mmio_address.f.reg_idx;
    assign eng_csr_glob.wr_data = mmio_writedata;

    for (genvar e = 0; e < MAX_ENG; e++)
    begin : g_eng
        if (e < NUM_ENG)
        begin : g_live
            // Only the engine named by eng_sel gets the strobe
            assign eng_csr[e].wr_en   = mmio_write && mmio_address.f.is_eng &&
                                        (mmio_address.f.eng_sel == 3'(e));
            assign eng_csr[e].wr_idx  = mmio_address.f.reg_idx;
            assign eng_csr[e].wr_data = mmio_writedata;
            assign eng_rd[e]          = eng_csr[e].rd_data;

            // A start to an idle engine with a nonzero count must show it busy
            // on the next cycle, which ties this decode to the engine FSM
            a_start_goes_active : assert property (
                @(posedge clk) disable iff (!arst_n)
                eng_csr[e].wr_en && (eng_csr[e].wr_idx == REG_CTRL) &&
                !eng_csr[e].status_active && (eng_csr[e].wr_data[31:0] != 32'd0)
                |=> eng_csr[e].status_active);
        end
        else
        begin : g_absent
            // Engine numbers beyond the build read as zero
            assign eng_rd[e] = '{default: '0};
        end
    end

    // ========================================
    // Read return
    // ========================================

    // Valid strobe follows the read by exactly one cycle
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mmio_readdatavalid <= 1'b0;
        end
        else
        begin
            mmio_readdatavalid <= mmio_read;
        end
    end

    // Read data is captured on the request cycle
    always_ff @(posedge clk)
    begin
        if (mmio_read)
        begin
            if (mmio_address.f.is_eng)
            begin
                mmio_readdata <= eng_rd[mmio_address.f.eng_sel][mmio_address.f.reg_idx];
            end
            else
            begin
                mmio_readdata <= eng_csr_glob.rd_data[mmio_address.f.reg_idx];
            end
        end
    end

    // The host issues one MMIO access per cycle
    a_no_rd_wr_overlap : assert property (
        @(posedge clk) disable iff (!arst_n)
        !(mmio_read && mmio_write));

endmodule

// ==== rtl/engine_csr_if.sv ====
// Register link between the CSR manager and one register block
// Write strobe towards the block, read words and a busy level back

`timescale 1ns/1ps

`include "rdwr_config.svh"

interface engine_csr_if;

    // One-cycle write strobe with its register index and data
    logic                    wr_en;
    logic [2:0]              wr_idx;
    logic [`RDWR_DATA_W-1:0] wr_data;

    // Every readable register of the block, always presented
    logic [`RDWR_DATA_W-1:0] rd_data [`RDWR_NUM_CSRS];

    // High while the block is running a job
    logic                    status_active;

    // The manager drives writes and samples the read side
    modport mgr (output wr_en, wr_idx, wr_data,
                 input  rd_data, status_active);

    // A block takes writes and presents its registers
    modport eng (input  wr_en, wr_idx, wr_data,
                 output rd_data, status_active);

endinterface

// ==== rtl/host_mem_rdwr_engine.sv ====
// Host memory copy engine with its control registers
// Pipelined reads, in-order return buffer, XOR write-back and a running checksum

`timescale 1ns/1ps

`include "rdwr_config.svh"

module host_mem_rdwr_engine
    import rdwr_pkg::*;
#(
    parameter int ENGINE_NUMBER = 0
)
(
    input  logic                    clk,
    input  logic                    arst_n,

    engine_csr_if.eng               csrs,

    output logic                    rd_read,
    output logic [`RDWR_ADDR_W-1:0] rd_address,
    input  logic                    rd_waitrequest,
    input  logic                    rd_readdatavalid,
    input  logic [`RDWR_DATA_W-1:0] rd_readdata,

    output logic                    wr_write,
    output logic [`RDWR_ADDR_W-1:0] wr_address,
    output logic [`RDWR_DATA_W-1:0] wr_writedata,
    input  logic                    wr_waitrequest
);

    localparam int MAX   = `RDWR_MAX_INFLIGHT;
    localparam int CNT_W = $clog2(MAX + 1);
    localparam int PTR_W = (MAX > 1) ? $clog2(MAX) : 1;

    // Software programmed job description
    logic [`RDWR_ADDR_W-1:0] rd_base;
    logic [`RDWR_ADDR_W-1:0] wr_base;
    logic [31:0]             num_lines;
    logic [`RDWR_DATA_W-1:0] xor_mask;

    logic                    active;
    logic                    done;
    logic                    start;

    // Progress of the job on each side
    logic [31:0]             rd_issued;
    logic [31:0]             wr_count;
    logic [CNT_W-1:0]        rd_outstanding;
    logic [CNT_W-1:0]        buf_count;
    logic [CNT_W-1:0]        credits;
    logic [`RDWR_DATA_W-1:0] checksum;

    // Return buffer holding words between read return and write acceptance
    logic [`RDWR_DATA_W-1:0] buf_mem [MAX];
    logic [PTR_W-1:0]        buf_wr_ptr;
    logic [PTR_W-1:0]        buf_rd_ptr;

    logic                    rd_fire;
    logic                    wr_fire;
    eng_status_t             status;

    // A start is only taken while idle, a busy engine ignores it
    assign start = csrs.wr_en && (csrs.wr_idx == REG_CTRL) && !active;

    // ========================================
    // Register writes and job state
    // ========================================

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rd_base   <= '0;
            wr_base   <= '0;
            num_lines <= '0;
            xor_mask  <= '0;
            active    <= 1'b0;
            done      <= 1'b0;
        end
        else
        begin
            if (csrs.wr_en && (csrs.wr_idx == REG_RD_BASE))
                rd_base <= csrs.wr_data[`RDWR_ADDR_W-1:0];
            if (csrs.wr_en && (csrs.wr_idx == REG_WR_BASE))
                wr_base <= csrs.wr_data[`RDWR_ADDR_W-1:0];
            if (csrs.wr_en && (csrs.wr_idx == REG_XOR))
                xor_mask <= csrs.wr_data;

            if (start)
            begin
                num_lines <= csrs.wr_data[31:0];
                // An empty job has nothing to move and finishes at once
                active    <= (csrs.wr_data[31:0] != 32'd0);
                done      <= (csrs.wr_data[31:0] == 32'd0);
            end
            else if (wr_fire && (wr_count + 32'd1 == num_lines))
            begin
                // Last write accepted
                active <= 1'b0;
                done   <= 1'b1;
            end
        end
    end

    // ========================================
    // Read issue and return
    // ========================================

    // Every slot is either a read in flight or a word waiting to be written
    assign credits    = CNT_W'(MAX) - rd_outstanding - buf_count;
    assign rd_read    = active && (rd_issued != num_lines) && (credits != '0);
    assign rd_address = rd_base + rd_issued;
    assign rd_fire    = rd_read && !rd_waitrequest;

    // Write side drains the buffer head, which stays put until accepted
    assign wr_write     = (buf_count != '0);
    assign wr_address   = wr_base + wr_count;
    assign wr_writedata = buf_mem[buf_rd_ptr] ^ xor_mask;
    assign wr_fire      = wr_write && !wr_waitrequest;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rd_issued      <= '0;
            wr_count       <= '0;
            rd_outstanding <= '0;
            buf_count      <= '0;
            buf_wr_ptr     <= '0;
            buf_rd_ptr     <= '0;
            checksum       <= '0;
        end
        else if (start)
        begin
            // Nothing is in flight while idle, so only the totals need clearing
            rd_issued <= '0;
            wr_count  <= '0;
            checksum  <= '0;
        end
        else
        begin
            if (rd_fire)
                rd_issued <= rd_issued + 32'd1;
            if (wr_fire)
                wr_count <= wr_count + 32'd1;

            case ({rd_fire, rd_readdatavalid})
                2'b10:   rd_outstanding <= rd_outstanding + 1'b1;
                2'b01:   rd_outstanding <= rd_outstanding - 1'b1;
                default: rd_outstanding <= rd_outstanding;
            endcase

            case ({rd_readdatavalid, wr_fire})
                2'b10:   buf_count <= buf_count + 1'b1;
                2'b01:   buf_count <= buf_count - 1'b1;
                default: buf_count <= buf_count;
            endcase

            if (rd_readdatavalid)
            begin
                // Checksum wraps at 64 bits
                checksum   <= checksum + rd_readdata;
                buf_wr_ptr <= (buf_wr_ptr == PTR_W'(MAX - 1)) ? '0 : buf_wr_ptr + 1'b1;
            end
            if (wr_fire)
                buf_rd_ptr <= (buf_rd_ptr == PTR_W'(MAX - 1)) ? '0 : buf_rd_ptr + 1'b1;
        end
    end

    // Buffer storage
    always_ff @(posedge clk)
    begin
        if (rd_readdatavalid)
            buf_mem[buf_wr_ptr] <= rd_readdata;
    end

    // ========================================
    // Register read side
    // ========================================

    always_comb
    begin
        status               = '0;
        status.active        = active;
        status.done          = done;
        status.lines_written = wr_count;

        for (int i = 0; i < `RDWR_NUM_CSRS; i++)
            csrs.rd_data[i] = '0;
        csrs.rd_data[REG_STATUS]   = status;
        csrs.rd_data[REG_CHECKSUM] = checksum;
        csrs.rd_data[REG_ENG_ID]   = `RDWR_DATA_W'(ENGINE_NUMBER);
        csrs.status_active         = active;
    end

    // Credit accounting must leave room for every returning word
    a_buf_no_overflow : assert property (
        @(posedge clk) disable iff (!arst_n)
        rd_readdatavalid |-> (buf_count != CNT_W'(MAX)));

    // Memory returns data only for reads it accepted
    a_rdv_has_read : assert property (
        @(posedge clk) disable iff (!arst_n)
        rd_readdatavalid |-> (rd_outstanding != '0));

endmodule

// ==== rtl/rdwr_config.svh ====
// Build-time sizes for the host-memory exerciser
// Bus widths, engine and register counts, read depth and test identifier

`ifndef RDWR_CONFIG_SVH
`define RDWR_CONFIG_SVH

// Width of MMIO data and of every host memory data word
`define RDWR_DATA_W 64

// Host memory word address width
`define RDWR_ADDR_W 32

// MMIO word address width, one bit of block type, three of engine, three of register
`define RDWR_MMIO_ADDR_W 7

// Engine count, the address map leaves room for at most 8
`define RDWR_NUM_ENGINES 2

// Registers in each block, global or engine
`define RDWR_NUM_CSRS 8

// Reads in flight plus words buffered per engine, also the return buffer depth
`define RDWR_MAX_INFLIGHT 8

// Software matches this identifier before it trusts the register map
`define RDWR_TEST_ID 128'h7d3e61a0_92c4_4f57_b8e2_0c5a19d46f3b

`endif

// ==== rtl/rdwr_pkg.sv ====
// Shared types for the exerciser
// MMIO address views, register index names and the engine status word

`include "rdwr_config.svh"

package rdwr_pkg;

    // Field view of an MMIO word address
    typedef struct packed {
        logic       is_eng;
        logic [2:0] eng_sel;
        logic [2:0] reg_idx;
    } mmio_addr_fields_t;

    // The same address seen either as a flat index or split into fields
    typedef union packed {
        logic [`RDWR_MMIO_ADDR_W-1:0] flat;
        mmio_addr_fields_t            f;
    } mmio_addr_u;

    // Engine registers on the write side
    localparam logic [2:0] REG_RD_BASE  = 3'd0;
    localparam logic [2:0] REG_WR_BASE  = 3'd1;
    // Low 32 bits hold the line count, a write here starts a job
    localparam logic [2:0] REG_CTRL     = 3'd2;
    localparam logic [2:0] REG_XOR      = 3'd3;

    // Engine registers on the read side
    localparam logic [2:0] REG_STATUS   = 3'd0;
    localparam logic [2:0] REG_CHECKSUM = 3'd1;
    localparam logic [2:0] REG_ENG_ID   = 3'd2;

    // Status word as software reads it
    typedef struct packed {
        logic        active;
        logic        done;
        logic [29:0] rsvd;
        logic [31:0] lines_written;
    } eng_status_t;

endpackage

// ==== sim/tb_afu.sv ====
// Testbench for the host-memory exerciser
// Clock, reset, MMIO tasks, host memory model, reference model, checks and tests

`timescale 1ns/1ps

`include "rdwr_config.svh"

module tb_afu
    import rdwr_pkg::*;
;

    localparam int NE = `RDWR_NUM_ENGINES;
    // Line counts of all jobs in the run, 40 cycles each plus slack for MMIO traffic
    localparam int TIMEOUT_CYCLES = (16 + 64 + 64 + 48 + 0 + 5) * 40 + 2000;

    logic                              clk = 1'b0;
    logic                              arst_n;
    logic [NE-1:0]                     host_rd_read;
    logic [NE-1:0][`RDWR_ADDR_W-1:0]   host_rd_address;
    logic [NE-1:0]                     host_rd_waitrequest;
    logic [NE-1:0]                     host_rd_readdatavalid;
    logic [NE-1:0][`RDWR_DATA_W-1:0]   host_rd_readdata;
    logic [NE-1:0]                     host_wr_write;
    logic [NE-1:0][`RDWR_ADDR_W-1:0]   host_wr_address;
    logic [NE-1:0][`RDWR_DATA_W-1:0]   host_wr_writedata;
    logic [NE-1:0]                     host_wr_waitrequest;
    logic                              mmio_write;
    logic                              mmio_read;
    logic [`RDWR_MMIO_ADDR_W-1:0]      mmio_address;
    logic [`RDWR_DATA_W-1:0]           mmio_writedata;
    logic [`RDWR_DATA_W-1:0]           mmio_readdata;
    logic                              mmio_readdatavalid;
    logic                              mmio_waitrequest;
    logic [1:0]                        mmio_response;

    // Host memory per engine, source words and the image written back
    logic [63:0] host_mem [NE][logic [31:0]];
    logic [63:0] wr_img   [NE][logic [31:0]];
    logic [63:0] exp_img  [NE][logic [31:0]];
    int          wr_cnt   [NE];
    logic [31:0] job_wr_base [NE];
    int          job_n    [NE];
    // Pending read returns, data and the negedge count when each may return
    logic [63:0] rd_data_q [NE][$];
    int          rd_due    [NE][$];

    logic [31:0] rng = 32'd17;
    bit          rand_wait = 1'b0;
    logic        rd_wait;
    logic        wr_wait;
    int          cyc = 0;
    int          cycles = 0;
    int          err_count = 0;
    int          check_count = 0;
    int          tests_run = 0;
    int          tests_bad = 0;

    afu dut0 (.*);

    always #4 clk = ~clk;

    // ========================================
    // Random numbers and memory contents
    // ========================================

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // Words never filled by a test still differ across the whole address
    function automatic logic [63:0] src_word(input int e, input logic [31:0] addr);
        if (host_mem[e].exists(addr))
            return host_mem[e][addr];
        return {~addr, addr ^ 32'h9e37_79b9} ^ 64'(e);
    endfunction

    // Expected write image and checksum of one copy job
    function automatic logic [63:0] ref_copy(input int e, input logic [31:0] rd_base,
                                             input logic [31:0] wr_base, input int n,
                                             input logic [63:0] mask);
        logic [63:0] sum;
        logic [63:0] w;
        sum = '0;
        exp_img[e].delete();
        for (int i = 0; i < n; i++)
        begin
            w = src_word(e, rd_base + 32'(i));
            sum = sum + w;
            exp_img[e][wr_base + 32'(i)] = w ^ mask;
        end
        return sum;
    endfunction

    // ========================================
    // Host memory model
    // ========================================

    // Decides waitrequest and read returns for the coming rising edge, so a
    // request seen here with waitrequest low is the one that transfers
    always @(negedge clk)
    begin
        if (arst_n)
        begin
            for (int e = 0; e < NE; e++)
            begin
                if (rd_due[e].size() != 0 && rd_due[e][0] <= cyc)
                begin
                    host_rd_readdatavalid[e] <= 1'b1;
                    host_rd_readdata[e]      <= rd_data_q[e].pop_front();
                    void'(rd_due[e].pop_front());
                end
                else
                begin
                    host_rd_readdatavalid[e] <= 1'b0;
                end
                rd_wait = rand_wait && (next_rand() % 4 == 0);
                wr_wait = rand_wait && (next_rand() % 4 == 0);
                host_rd_waitrequest[e] <= rd_wait;
                host_wr_waitrequest[e] <= wr_wait;
                if (host_rd_read[e] && !rd_wait)
                begin
                    rd_data_q[e].push_back(src_word(e, host_rd_address[e]));
                    rd_due[e].push_back(cyc + 1 + int'(next_rand() % 4));
                end
                if (host_wr_write[e] && !wr_wait)
                    record_write(e, host_wr_address[e], host_wr_writedata[e]);
            end
        end
        cyc++;
    end

    task automatic record_write(input int e, input logic [31:0] addr, input logic [63:0] d);
        if (addr < job_wr_base[e] || addr >= job_wr_base[e] + 32'(job_n[e]))
        begin
            $display("FAIL @%0t: engine %0d wrote outside its window at %h", $time, e, addr);
            err_count++;
        end
        wr_img[e][addr] = d;
        wr_cnt[e]++;
    endtask

    // Hard stop if a job or a read never completes
    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ========================================
    // MMIO access and compare tasks
    // ========================================

    function automatic mmio_addr_u eng_reg(input int e, input logic [2:0] idx);
        mmio_addr_u a;
        a.f.is_eng  = 1'b1;
        a.f.eng_sel = 3'(e);
        a.f.reg_idx = idx;
        return a;
    endfunction

    function automatic mmio_addr_u glob_reg(input logic [2:0] idx);
        mmio_addr_u a;
        a.f.is_eng  = 1'b0;
        a.f.eng_sel = 3'd0;
        a.f.reg_idx = idx;
        return a;
    endfunction

    task automatic mmio_wr(input mmio_addr_u a, input logic [63:0] d);
        @(negedge clk);
        mmio_write     = 1'b1;
        mmio_address   = a.flat;
        mmio_writedata = d;
        // The bus takes every access at once
        check_word("mmio waitrequest", 64'(mmio_waitrequest), 64'd0);
        @(negedge clk);
        mmio_write = 1'b0;
    endtask

    task automatic mmio_rd(input mmio_addr_u a, output logic [63:0] d);
        @(negedge clk);
        mmio_read    = 1'b1;
        mmio_address = a.flat;
        check_word("mmio waitrequest", 64'(mmio_waitrequest), 64'd0);
        @(negedge clk);
        mmio_read = 1'b0;
        // Registered data is due exactly one cycle after the request
        if (!mmio_readdatavalid)
        begin
            $display("At %0t the MMIO read data was not valid one cycle after the read",
                     $time);
            err_count++;
        end
        while (!mmio_readdatavalid)
            @(negedge clk);
        d = mmio_readdata;
        check_word("mmio response", 64'(mmio_response), 64'd0);
    endtask

    task automatic check_word(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
        check_count++;
        if (got !== exp)
        begin
            $display("FAIL @%0t: %s got %h expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_status(input string what, input eng_status_t got,
                                input eng_status_t exp);
        check_count++;
        if (got !== exp)
        begin
            $display("FAIL @%0t: %s active %b done %b lines %0d, expected %b %b %0d",
                     $time, what, got.active, got.done, got.lines_written,
                     exp.active, exp.done, exp.lines_written);
            err_count++;
        end
    endtask

    task automatic check_mem(input int e, input logic [31:0] addr, input logic [63:0] got,
                             input logic [63:0] exp);
        check_count++;
        if (got !== exp)
        begin
            $display("FAIL @%0t: engine %0d word at %h got %h expected %h",
                     $time, e, addr, got, exp);
            err_count++;
        end
    endtask

    // ========================================
    // Job helpers
    // ========================================

    // Fills the source window and programs everything but the start
    task automatic setup_job(input int e, input logic [31:0] rd_base,
                             input logic [31:0] wr_base, input int n, input logic [63:0] mask);
        for (int i = 0; i < n; i++)
            host_mem[e][rd_base + 32'(i)] = {next_rand(), next_rand()};
        wr_img[e].delete();
        wr_cnt[e]      = 0;
        job_wr_base[e] = wr_base;
        job_n[e]       = n;
        mmio_wr(eng_reg(e, REG_RD_BASE), 64'(rd_base));
        mmio_wr(eng_reg(e, REG_WR_BASE), 64'(wr_base));
        mmio_wr(eng_reg(e, REG_XOR), mask);
    endtask

    task automatic wait_done(input int e);
        logic [63:0] d;
        eng_status_t st;
        st = '0;
        while (!(st.done && !st.active))
        begin
            mmio_rd(eng_reg(e, REG_STATUS), d);
            st = eng_status_t'(d);
        end
    endtask

    task automatic verify_job(input int e, input logic [31:0] rd_base, input int n,
                              input logic [63:0] mask);
        logic [63:0] d;
        logic [63:0] exp_sum;
        logic [31:0] a;
        eng_status_t exp_st;
        exp_sum = ref_copy(e, rd_base, job_wr_base[e], n, mask);
        exp_st  = '0;
        exp_st.done          = 1'b1;
        exp_st.lines_written = 32'(n);
        mmio_rd(eng_reg(e, REG_STATUS), d);
        check_status($sformatf("engine %0d status", e), eng_status_t'(d), exp_st);
        mmio_rd(eng_reg(e, REG_CHECKSUM), d);
        check_word($sformatf("engine %0d checksum", e), d, exp_sum);
        check_word($sformatf("engine %0d write count", e), 64'(wr_cnt[e]), 64'(n));
        // Walk this engine's write window only
        for (int i = 0; i < n; i++)
        begin
            a = job_wr_base[e] + 32'(i);
            if (!wr_img[e].exists(a))
            begin
                $display("Engine %0d never wrote address %h", e, a);
                err_count++;
            end
            else
                check_mem(e, a, wr_img[e][a], exp_img[e][a]);
        end
    endtask

    task automatic test_report(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before)
            $display("test %0d %s: ok", tests_run, name);
        else
        begin
            tests_bad++;
            $display("test %0d %s: %0d errors", tests_run, name, err_count - errs_before);
        end
    endtask

    // ========================================
    // Tests
    // ========================================

    initial
    begin
        logic [63:0] d;
        logic [127:0] tid;
        int          e0;
        eng_status_t exp_st;
        tid = `RDWR_TEST_ID;
        arst_n = 1'b0;
        mmio_write = 1'b0;
        mmio_read = 1'b0;
        mmio_address = '0;
        mmio_writedata = '0;
        host_rd_waitrequest = '0;
        host_rd_readdatavalid = '0;
        host_rd_readdata = '0;
        host_wr_waitrequest = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // Identification registers and an engine slot past the build
        e0 = err_count;
        mmio_rd(glob_reg(3'd0), d);
        check_word("test id low", d, tid[63:0]);
        mmio_rd(glob_reg(3'd1), d);
        check_word("test id high", d, tid[127:64]);
        mmio_rd(glob_reg(3'd2), d);
        check_word("engine count", d, 64'(NE));
        mmio_rd(eng_reg(5, REG_STATUS), d);
        check_word("absent engine", d, 64'd0);
        for (int e = 0; e < NE; e++)
        begin
            mmio_rd(eng_reg(e, REG_ENG_ID), d);
            check_word("engine id", d, 64'(e));
        end
        test_report("registers", e0);

        // Short copy with an idle bus
        e0 = err_count;
        setup_job(0, 32'h100, 32'h800, 16, 64'hf0f0_0ff0_a5a5_5a5a);
        mmio_wr(eng_reg(0, REG_CTRL), 64'd16);
        wait_done(0);
        verify_job(0, 32'h100, 16, 64'hf0f0_0ff0_a5a5_5a5a);
        test_report("single copy", e0);

        // Both engines under back-pressure and random read latency
        e0 = err_count;
        rand_wait = 1'b1;
        setup_job(0, 32'h1000, 32'h2000, 64, 64'h0123_4567_89ab_cdef);
        setup_job(1, 32'h1000, 32'h3000, 64, 64'hffff_0000_ffff_0000);
        mmio_wr(eng_reg(0, REG_CTRL), 64'd64);
        mmio_wr(eng_reg(1, REG_CTRL), 64'd64);
        wait_done(0);
        wait_done(1);
        verify_job(0, 32'h1000, 64, 64'h0123_4567_89ab_cdef);
        verify_job(1, 32'h1000, 64, 64'hffff_0000_ffff_0000);
        test_report("dual copy", e0);

        // Second start lands while the first job runs
        e0 = err_count;
        setup_job(0, 32'h4000, 32'h5000, 48, 64'h3c3c_3c3c_c3c3_c3c3);
        mmio_wr(eng_reg(0, REG_CTRL), 64'd48);
        mmio_wr(eng_reg(0, REG_CTRL), 64'd7);
        wait_done(0);
        verify_job(0, 32'h4000, 48, 64'h3c3c_3c3c_c3c3_c3c3);
        test_report("busy start", e0);

        // Empty job, then a short one that must clear done
        e0 = err_count;
        rand_wait = 1'b0;
        setup_job(1, 32'h6000, 32'h7000, 0, 64'h0);
        mmio_wr(eng_reg(1, REG_CTRL), 64'd0);
        wait_done(1);
        verify_job(1, 32'h6000, 0, 64'h0);
        setup_job(1, 32'h6000, 32'h7000, 5, 64'h5555_aaaa_5555_aaaa);
        mmio_wr(eng_reg(1, REG_CTRL), 64'd5);
        mmio_rd(eng_reg(1, REG_STATUS), d);
        exp_st = '0;
        exp_st.active = 1'b1;
        check_status("engine 1 running", eng_status_t'(d), exp_st);
        wait_done(1);
        verify_job(1, 32'h6000, 5, 64'h5555_aaaa_5555_aaaa);
        test_report("zero length", e0);

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_bad, check_count, err_count);
        if (err_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule
